// ==== common/rv_pkg.sv ====
package rv_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // major opcodes from instruction bits 6..2
    localparam logic [4:0] OPC_LOAD     = 5'b00000;
    localparam logic [4:0] OPC_MISC_MEM = 5'b00011;
    localparam logic [4:0] OPC_OP_IMM   = 5'b00100;
    localparam logic [4:0] OPC_AUIPC    = 5'b00101;
    localparam logic [4:0] OPC_STORE    = 5'b01000;
    localparam logic [4:0] OPC_OP       = 5'b01100;
    localparam logic [4:0] OPC_LUI      = 5'b01101;
    localparam logic [4:0] OPC_BRANCH   = 5'b11000;
    localparam logic [4:0] OPC_JALR     = 5'b11001;
    localparam logic [4:0] OPC_JAL      = 5'b11011;
    localparam logic [4:0] OPC_SYSTEM   = 5'b11100;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_OR,
        ALU_AND,
        ALU_XOR,
        ALU_SLT,
        ALU_SHIFT
    } alu_op_e;

    // destination write data source
    typedef enum logic [1:0] {
        RD_ALU,
        RD_MEM,
        RD_PC4
    } rd_sel_e;

    // same encoding as funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        MEM_BYTE = 2'b00,
        MEM_HALF = 2'b01,
        MEM_WORD = 2'b10
    } mem_width_e;

    typedef enum logic {
        SHIFT_LEFT,
        SHIFT_RIGHT
    } shift_dir_e;

endpackage

// ==== rtl/rv_fetch.sv ====
module rv_fetch
    import rv_pkg::*;
#(
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input  logic            i_clk,
    input  logic            i_rst_n,
    input  logic            i_redirect,
    input  logic [XLEN-1:0] i_target,
    output logic [XLEN-1:0] o_pc,
    output logic [XLEN-1:0] o_pc_plus4
);

    logic [XLEN-1:0] next_pc;

    assign o_pc_plus4 = o_pc + XLEN'(4);

    // jump targets drop bit 0
    assign next_pc = i_redirect ? {i_target[XLEN-1:1], 1'b0} : o_pc_plus4;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_pc <= RESET_PC;
        end else begin
            o_pc <= next_pc;
        end
    end

endmodule

// ==== decode/rv_decoder.sv ====
module rv_decoder
    import rv_pkg::*;
(
    input  logic [XLEN-1:0]       i_inst,
    output logic [REG_ADDR_W-1:0] o_rs1_addr,
    output logic [REG_ADDR_W-1:0] o_rs2_addr,
    output logic [REG_ADDR_W-1:0] o_rd_addr,
    output logic                  o_rd_wen,
    output rd_sel_e               o_rd_sel,
    output logic                  o_op1_pc,
    output logic                  o_op2_imm,
    output logic                  o_cmp_imm,
    output alu_op_e               o_alu_op,
    output logic                  o_alu_sub,
    output logic                  o_slt_unsigned,
    output shift_dir_e            o_shift_dir,
    output logic                  o_shift_arith,
    output logic                  o_jump,
    output logic                  o_branch,
    output logic                  o_br_equal,
    output logic                  o_br_unsigned,
    output logic                  o_br_invert,
    output logic [XLEN-1:0]       o_imm,
    output logic                  o_mem_ren,
    output logic                  o_mem_wen,
    output mem_width_e            o_mem_width,
    output logic                  o_mem_unsigned
);

    logic [4:0]      opcode;
    logic [2:0]      funct3;
    logic            funct7_b5;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;
    alu_op_e         f3_op;

    assign opcode    = i_inst[6:2];
    assign funct3    = i_inst[14:12];
    assign funct7_b5 = i_inst[30];

    assign imm_i = {{20{i_inst[31]}}, i_inst[31:20]};
    assign imm_s = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
    assign imm_b = {{19{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
    assign imm_u = {i_inst[31:12], 12'b0};
    assign imm_j = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

    // lui adds its immediate to x0
    assign o_rs1_addr = (opcode == OPC_LUI) ? '0 : i_inst[19:15];
    assign o_rs2_addr = i_inst[24:20];
    assign o_rd_addr  = i_inst[11:7];

    assign o_slt_unsigned = funct3[0];
    assign o_shift_dir    = funct3[2] ? SHIFT_RIGHT : SHIFT_LEFT;
    assign o_shift_arith  = funct7_b5;
    assign o_br_equal     = !funct3[2];
    assign o_br_unsigned  = funct3[1];
    assign o_br_invert    = funct3[0];
    assign o_mem_width    = mem_width_e'(funct3[1:0]);
    assign o_mem_unsigned = funct3[2];

    always_comb begin
        case (funct3)
            3'b001, 3'b101: f3_op = ALU_SHIFT;
            3'b010, 3'b011: f3_op = ALU_SLT;
            3'b100:         f3_op = ALU_XOR;
            3'b110:         f3_op = ALU_OR;
            3'b111:         f3_op = ALU_AND;
            default:        f3_op = ALU_ADD;
        endcase
    end

    always_comb begin
        o_rd_wen  = 1'b0;
        o_rd_sel  = RD_ALU;
        o_op1_pc  = 1'b0;
        o_op2_imm = 1'b1;
        o_cmp_imm = 1'b0;
        o_alu_op  = ALU_ADD;
        o_alu_sub = 1'b0;
        o_jump    = 1'b0;
        o_branch  = 1'b0;
        o_mem_ren = 1'b0;
        o_mem_wen = 1'b0;
        o_imm     = imm_i;
        case (opcode)
            OPC_LUI: begin
                o_rd_wen = 1'b1;
                o_imm    = imm_u;
            end
            OPC_AUIPC: begin
                o_rd_wen = 1'b1;
                o_op1_pc = 1'b1;
                o_imm    = imm_u;
            end
            OPC_JAL: begin
                o_rd_wen = 1'b1;
                o_rd_sel = RD_PC4;
                o_op1_pc = 1'b1;
                o_jump   = 1'b1;
                o_imm    = imm_j;
            end
            OPC_JALR: begin
                o_rd_wen = 1'b1;
                o_rd_sel = RD_PC4;
                o_jump   = 1'b1;
            end
            OPC_BRANCH: begin
                o_op1_pc = 1'b1;
                o_branch = 1'b1;
                o_imm    = imm_b;
            end
            OPC_LOAD: begin
                o_rd_wen  = 1'b1;
                o_rd_sel  = RD_MEM;
                o_mem_ren = 1'b1;
            end
            OPC_STORE: begin
                o_mem_wen = 1'b1;
                o_imm     = imm_s;
            end
            OPC_OP_IMM: begin
                o_rd_wen  = 1'b1;
                o_cmp_imm = 1'b1;
                o_alu_op  = f3_op;
            end
            OPC_OP: begin
                o_rd_wen  = 1'b1;
                o_op2_imm = 1'b0;
                o_alu_op  = f3_op;
                o_alu_sub = (funct3 == 3'b000) && funct7_b5;
            end
            // fence and system retire as nops
            OPC_MISC_MEM, OPC_SYSTEM: begin
                o_rd_wen = 1'b0;
            end
            default: begin
                o_rd_wen = 1'b0;
            end
        endcase
    end

endmodule

// ==== exec/rv_regfile.sv ====
module rv_regfile
    import rv_pkg::*;
(
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic [REG_ADDR_W-1:0] i_rs1_addr,
    input  logic [REG_ADDR_W-1:0] i_rs2_addr,
    input  logic [REG_ADDR_W-1:0] i_rd_addr,
    input  logic                  i_rd_wen,
    input  logic [XLEN-1:0]       i_rd_wdata,
    output logic [XLEN-1:0]       o_rs1_rdata,
    output logic [XLEN-1:0]       o_rs2_rdata
);

    // x0 has no storage
    logic [XLEN-1:0] regs [1:2**REG_ADDR_W-1];

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 1; i < 2**REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (i_rd_wen && (i_rd_addr != '0)) begin
            regs[i_rd_addr] <= i_rd_wdata;
        end
    end

    assign o_rs1_rdata = (i_rs1_addr == '0) ? '0 : regs[i_rs1_addr];
    assign o_rs2_rdata = (i_rs2_addr == '0) ? '0 : regs[i_rs2_addr];

endmodule

// ==== exec/rv_branch_unit.sv ====
module rv_branch_unit (
    input  logic [31:0] i_op1,
    input  logic [31:0] i_op2,
    input  logic        i_jump,
    input  logic        i_branch,
    input  logic        i_equal,
    input  logic        i_unsigned,
    input  logic        i_invert,
    output logic        o_lt,
    output logic        o_ltu,
    output logic        o_redirect
);

    logic eq;
    logic lt_low;
    logic lt_acc;
    logic take;

    assign eq = &(i_op1 ~^ i_op2);

    // ripple from lsb so a higher differing bit overrides the lower result
    always_comb begin
        lt_acc = 1'b0;
        lt_low = 1'b0;
        for (int i = 0; i < 32; i++) begin
            lt_acc = (!i_op1[i] && i_op2[i]) || ((i_op1[i] == i_op2[i]) && lt_acc);
            if (i == 30) begin
                lt_low = lt_acc;
            end
        end
    end

    assign o_ltu = lt_acc;
    assign o_lt  = (i_op1[31] == i_op2[31]) ? lt_low : i_op1[31];

    assign take       = (i_equal ? eq : (i_unsigned ? o_ltu : o_lt)) ^ i_invert;
    assign o_redirect = i_jump || (i_branch && take);

endmodule

// ==== exec/rv_alu.sv ====
module rv_alu
    import rv_pkg::*;
(
    input  alu_op_e         i_op,
    input  logic            i_sub,
    input  logic            i_slt_unsigned,
    input  shift_dir_e      i_shift_dir,
    input  logic            i_shift_arith,
    input  logic [XLEN-1:0] i_op1,
    input  logic [XLEN-1:0] i_op2,
    input  logic            i_lt,
    input  logic            i_ltu,
    output logic [XLEN-1:0] o_result
);

    logic [XLEN-1:0] op2_eff;
    logic [XLEN-1:0] prop;
    logic [XLEN-1:0] gen;
    logic [XLEN-1:0] sum;
    logic            carry;
    logic            left;
    logic            fill;
    logic [XLEN-1:0] stage;
    logic [XLEN-1:0] shift_res;

    // subtract by inverting op2 with carry-in set
    assign op2_eff = i_op2 ^ {XLEN{i_sub}};
    assign prop    = i_op1 ^ op2_eff;
    assign gen     = i_op1 & op2_eff;

    always_comb begin
        carry = i_sub;
        for (int i = 0; i < XLEN; i++) begin
            sum[i] = prop[i] ^ carry;
            carry  = gen[i] | (prop[i] & carry);
        end
    end

    // left shifts run through the right shifter bit-reversed
    assign left = (i_shift_dir == SHIFT_LEFT);
    assign fill = !left && i_shift_arith && i_op1[XLEN-1];

    always_comb begin
        for (int i = 0; i < XLEN; i++) begin
            stage[i] = left ? i_op1[XLEN-1-i] : i_op1[i];
        end
        if (i_op2[4]) begin
            stage = {{16{fill}}, stage[31:16]};
        end
        if (i_op2[3]) begin
            stage = {{8{fill}}, stage[31:8]};
        end
        if (i_op2[2]) begin
            stage = {{4{fill}}, stage[31:4]};
        end
        if (i_op2[1]) begin
            stage = {{2{fill}}, stage[31:2]};
        end
        if (i_op2[0]) begin
            stage = {fill, stage[31:1]};
        end
        for (int i = 0; i < XLEN; i++) begin
            shift_res[i] = left ? stage[XLEN-1-i] : stage[i];
        end
    end

    always_comb begin
        case (i_op)
            ALU_OR:    o_result = prop | gen;
            ALU_AND:   o_result = gen;
            ALU_XOR:   o_result = prop;
            ALU_SLT:   o_result = {{(XLEN-1){1'b0}}, i_slt_unsigned ? i_ltu : i_lt};
            ALU_SHIFT: o_result = shift_res;
            default:   o_result = sum;
        endcase
    end

endmodule

// ==== lsu/rv_store_align.sv ====
module rv_store_align
    import rv_pkg::*;
(
    input  logic [XLEN-1:0] i_addr,
    input  logic [XLEN-1:0] i_rs2,
    input  logic            i_wen,
    input  mem_width_e      i_width,
    output logic [XLEN-1:0] o_dmem_addr,
    output logic [XLEN-1:0] o_dmem_wdata,
    output logic [3:0]      o_dmem_wmask
);

    logic [3:0] lane_mask;

    assign o_dmem_addr = {i_addr[XLEN-1:2], 2'b00};

    always_comb begin
        case (i_width)
            MEM_BYTE: begin
                lane_mask    = 4'b0001 << i_addr[1:0];
                o_dmem_wdata = i_rs2 << {i_addr[1:0], 3'b000};
            end
            MEM_HALF: begin
                lane_mask    = i_addr[1] ? 4'b1100 : 4'b0011;
                o_dmem_wdata = i_addr[1] ? {i_rs2[15:0], 16'h0000} : i_rs2;
            end
            default: begin
                lane_mask    = 4'b1111;
                o_dmem_wdata = i_rs2;
            end
        endcase
    end

    assign o_dmem_wmask = lane_mask & {4{i_wen}};

endmodule

// ==== lsu/rv_load_writeback.sv ====
module rv_load_writeback
    import rv_pkg::*;
(
    input  logic [1:0]      i_addr_lsb,
    input  mem_width_e      i_width,
    input  logic            i_unsigned,
    input  logic [XLEN-1:0] i_dmem_rdata,
    input  rd_sel_e         i_rd_sel,
    input  logic [XLEN-1:0] i_alu_result,
    input  logic [XLEN-1:0] i_pc_plus4,
    output logic [XLEN-1:0] o_rd_wdata
);

    logic [15:0]     half;
    logic [7:0]      byte_sel;
    logic            sign;
    logic [XLEN-1:0] load_data;

    assign half     = i_addr_lsb[1] ? i_dmem_rdata[31:16] : i_dmem_rdata[15:0];
    assign byte_sel = i_addr_lsb[0] ? half[15:8] : half[7:0];

    always_comb begin
        case (i_width)
            MEM_BYTE: begin
                sign      = !i_unsigned && byte_sel[7];
                load_data = {{24{sign}}, byte_sel};
            end
            MEM_HALF: begin
                sign      = !i_unsigned && half[15];
                load_data = {{16{sign}}, half};
            end
            default: begin
                sign      = 1'b0;
                load_data = i_dmem_rdata;
            end
        endcase
    end

    always_comb begin
        case (i_rd_sel)
            RD_MEM:  o_rd_wdata = load_data;
            RD_PC4:  o_rd_wdata = i_pc_plus4;
            default: o_rd_wdata = i_alu_result;
        endcase
    end

endmodule

// ==== rtl/rv_core.sv ====
module rv_core
    import rv_pkg::*;
#(
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input  logic            i_clk,
    input  logic            i_rst_n,
    output logic [XLEN-1:0] o_imem_addr,
    input  logic [XLEN-1:0] i_imem_rdata,
    output logic [XLEN-1:0] o_dmem_addr,
    output logic [XLEN-1:0] o_dmem_wdata,
    output logic [3:0]      o_dmem_wmask,
    output logic            o_dmem_ren,
    input  logic [XLEN-1:0] i_dmem_rdata
);

    logic [XLEN-1:0]       pc;
    logic [XLEN-1:0]       pc_plus4;
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [REG_ADDR_W-1:0] rd_addr;
    logic                  rd_wen;
    rd_sel_e               rd_sel;
    logic                  op1_pc;
    logic                  op2_imm;
    logic                  cmp_imm;
    alu_op_e               alu_op;
    logic                  alu_sub;
    logic                  slt_unsigned;
    shift_dir_e            shift_dir;
    logic                  shift_arith;
    logic                  jump;
    logic                  branch;
    logic                  br_equal;
    logic                  br_unsigned;
    logic                  br_invert;
    logic [XLEN-1:0]       imm;
    logic                  mem_wen;
    mem_width_e            mem_width;
    logic                  mem_unsigned;
    logic [XLEN-1:0]       rs1_rdata;
    logic [XLEN-1:0]       rs2_rdata;
    logic [XLEN-1:0]       rd_wdata;
    logic                  lt;
    logic                  ltu;
    logic                  redirect;
    logic [XLEN-1:0]       alu_result;

    // operand routing between regfile, immediate and pc
    wire [XLEN-1:0] alu_op1 = op1_pc ? pc : rs1_rdata;
    wire [XLEN-1:0] alu_op2 = op2_imm ? imm : rs2_rdata;
    wire [XLEN-1:0] cmp_op2 = cmp_imm ? imm : rs2_rdata;

    assign o_imem_addr = pc;

    rv_fetch #(
        .RESET_PC(RESET_PC)
    ) fetch_i (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_redirect (redirect),
        .i_target   (alu_result),
        .o_pc       (pc),
        .o_pc_plus4 (pc_plus4)
    );

    rv_decoder decoder_i (
        .i_inst         (i_imem_rdata),
        .o_rs1_addr     (rs1_addr),
        .o_rs2_addr     (rs2_addr),
        .o_rd_addr      (rd_addr),
        .o_rd_wen       (rd_wen),
        .o_rd_sel       (rd_sel),
        .o_op1_pc       (op1_pc),
        .o_op2_imm      (op2_imm),
        .o_cmp_imm      (cmp_imm),
        .o_alu_op       (alu_op),
        .o_alu_sub      (alu_sub),
        .o_slt_unsigned (slt_unsigned),
        .o_shift_dir    (shift_dir),
        .o_shift_arith  (shift_arith),
        .o_jump         (jump),
        .o_branch       (branch),
        .o_br_equal     (br_equal),
        .o_br_unsigned  (br_unsigned),
        .o_br_invert    (br_invert),
        .o_imm          (imm),
        .o_mem_ren      (o_dmem_ren),
        .o_mem_wen      (mem_wen),
        .o_mem_width    (mem_width),
        .o_mem_unsigned (mem_unsigned)
    );

    rv_regfile regfile_i (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_rs1_addr  (rs1_addr),
        .i_rs2_addr  (rs2_addr),
        .i_rd_addr   (rd_addr),
        .i_rd_wen    (rd_wen),
        .i_rd_wdata  (rd_wdata),
        .o_rs1_rdata (rs1_rdata),
        .o_rs2_rdata (rs2_rdata)
    );

    rv_branch_unit branch_i (
        .i_op1      (rs1_rdata),
        .i_op2      (cmp_op2),
        .i_jump     (jump),
        .i_branch   (branch),
        .i_equal    (br_equal),
        .i_unsigned (br_unsigned),
        .i_invert   (br_invert),
        .o_lt       (lt),
        .o_ltu      (ltu),
        .o_redirect (redirect)
    );

    rv_alu alu_i (
        .i_op           (alu_op),
        .i_sub          (alu_sub),
        .i_slt_unsigned (slt_unsigned),
        .i_shift_dir    (shift_dir),
        .i_shift_arith  (shift_arith),
        .i_op1          (alu_op1),
        .i_op2          (alu_op2),
        .i_lt           (lt),
        .i_ltu          (ltu),
        .o_result       (alu_result)
    );

    rv_store_align store_i (
        .i_addr       (alu_result),
        .i_rs2        (rs2_rdata),
        .i_wen        (mem_wen),
        .i_width      (mem_width),
        .o_dmem_addr  (o_dmem_addr),
        .o_dmem_wdata (o_dmem_wdata),
        .o_dmem_wmask (o_dmem_wmask)
    );

    rv_load_writeback writeback_i (
        .i_addr_lsb   (alu_result[1:0]),
        .i_width      (mem_width),
        .i_unsigned   (mem_unsigned),
        .i_dmem_rdata (i_dmem_rdata),
        .i_rd_sel     (rd_sel),
        .i_alu_result (alu_result),
        .i_pc_plus4   (pc_plus4),
        .o_rd_wdata   (rd_wdata)
    );

endmodule

// ==== tb/tb_iss.svh ====
`ifndef TB_ISS_SVH
`define TB_ISS_SVH

// reference model state
logic [31:0] mreg [0:31];
logic [31:0] mpc;
logic [31:0] mmem [0:255];

// memory seed that differs in every word
function automatic logic [31:0] fill_word(input logic [31:0] idx);
    return (idx * 32'h9e3779b1) ^ {idx[7:0], ~idx[7:0], idx[15:0]};
endfunction

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd, input logic [4:0] opc);
    return {f7, rs2, rs1, f3, rd, opc, 2'b11};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [4:0] opc);
    return {imm, rs1, f3, rd, opc, 2'b11};
endfunction

function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE, 2'b11};
endfunction

function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH, 2'b11};
endfunction

function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                      input logic [4:0] opc);
    return {imm, rd, opc, 2'b11};
endfunction

function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL, 2'b11};
endfunction

function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic sub,
                                          input logic sra, input logic [31:0] a,
                                          input logic [31:0] b);
    case (f3)
        3'd0:    return sub ? a - b : a + b;
        3'd1:    return a << b[4:0];
        3'd2:    return {31'b0, $signed(a) < $signed(b)};
        3'd3:    return {31'b0, a < b};
        3'd4:    return a ^ b;
        3'd5:    return sra ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'd6:    return a | b;
        default: return a & b;
    endcase
endfunction

// steps one instruction and returns the expected store mask, address and data
task automatic iss_step(input logic [31:0] inst, output logic [3:0] wm,
                        output logic [31:0] wa, output logic [31:0] wd);
    logic [4:0]  opc;
    logic [2:0]  f3;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] immi;
    logic [31:0] res;
    logic [31:0] ea;
    logic [31:0] word;
    logic [31:0] nxt;
    logic        wr;
    logic        take;
    opc  = inst[6:2];
    f3   = inst[14:12];
    a    = mreg[inst[19:15]];
    b    = mreg[inst[24:20]];
    immi = {{20{inst[31]}}, inst[31:20]};
    nxt  = mpc + 4;
    wr   = 1'b0;
    res  = '0;
    wm   = '0;
    wa   = '0;
    wd   = '0;
    case (opc)
        OPC_LUI:   {wr, res} = {1'b1, inst[31:12], 12'b0};
        OPC_AUIPC: {wr, res} = {1'b1, mpc + {inst[31:12], 12'b0}};
        OPC_JAL: begin
            {wr, res} = {1'b1, mpc + 32'd4};
            nxt = mpc + {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
        end
        OPC_JALR: begin
            {wr, res} = {1'b1, mpc + 32'd4};
            nxt = (a + immi) & ~32'd1;
        end
        OPC_BRANCH: begin
            case (f3)
                3'd0:    take = (a == b);
                3'd1:    take = (a != b);
                3'd4:    take = ($signed(a) < $signed(b));
                3'd5:    take = ($signed(a) >= $signed(b));
                3'd6:    take = (a < b);
                default: take = (a >= b);
            endcase
            if (take) begin
                nxt = mpc + {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            end
        end
        OPC_LOAD: begin
            ea   = a + immi;
            word = mmem[ea[9:2]] >> {ea[1:0], 3'b000};
            wr   = 1'b1;
            case (f3)
                3'd0:    res = {{24{word[7]}}, word[7:0]};
                3'd1:    res = {{16{word[15]}}, word[15:0]};
                3'd4:    res = {24'b0, word[7:0]};
                3'd5:    res = {16'b0, word[15:0]};
                default: res = word;
            endcase
        end
        OPC_STORE: begin
            ea = a + {{20{inst[31]}}, inst[31:25], inst[11:7]};
            wa = {ea[31:2], 2'b00};
            wd = b << {ea[1:0], 3'b000};
            wm = (f3 == 3'd0) ? 4'b0001 << ea[1:0] :
                 (f3 == 3'd1) ? 4'b0011 << ea[1:0] : 4'b1111;
            for (int i = 0; i < 4; i++) begin
                if (wm[i]) begin
                    mmem[ea[9:2]][8*i +: 8] = wd[8*i +: 8];
                end
            end
        end
        OPC_OP_IMM: {wr, res} = {1'b1, alu_model(f3, 1'b0, inst[30], a, immi)};
        OPC_OP:     {wr, res} = {1'b1, alu_model(f3, inst[30], inst[30], a, b)};
        default:    wr = 1'b0;
    endcase
    if (wr && inst[11:7] != 5'd0) begin
        mreg[inst[11:7]] = res;
    end
    mpc = nxt;
endtask

`endif

// ==== tb/tb_rv_core.sv ====
module tb_rv_core import rv_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] RESET_PC = 32'h0000_0100;
    localparam logic [31:0] NOP      = 32'h0000_0013;
    localparam int N_ALU   = 300;
    localparam int N_LOAD  = 60;
    localparam int N_FLOW  = 60;
    localparam int MAX_CYCLES = 3 + 1 + N_ALU + 31 + 2 * N_LOAD + 36 + 5 * N_FLOW + 1 + 100;

    logic        i_clk;
    logic        i_rst_n;
    logic [31:0] o_imem_addr;
    logic [31:0] i_imem_rdata;
    logic [31:0] o_dmem_addr;
    logic [31:0] o_dmem_wdata;
    logic [3:0]  o_dmem_wmask;
    logic        o_dmem_ren;
    logic [31:0] i_dmem_rdata;

    logic [31:0] prog [0:1023];
    logic [31:0] dmem [0:255];
    logic [31:0] emit_pc;
    int          errors;
    int          n_pass;
    int          n_fail;
    int          cycles;

    `include "tb_iss.svh"

    rv_core #(.RESET_PC(RESET_PC)) rv_core_i (.*);

    always #5 i_clk = ~i_clk;

    assign i_dmem_rdata = dmem[o_dmem_addr[9:2]];

    always @(posedge i_clk) begin
        for (int i = 0; i < 4; i++) begin
            if (o_dmem_wmask[i]) begin
                dmem[o_dmem_addr[9:2]][8*i +: 8] <= o_dmem_wdata[8*i +: 8];
            end
        end
    end

    always @(posedge i_clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, the program never reached its end", cycles);
            $display("TEST FAIL");
            $finish;
        end
    end

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("ERR t=%0t %s expected %h got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic emit(input logic [31:0] inst);
        prog[(emit_pc - RESET_PC) >> 2] = inst;
        emit_pc += 4;
    endtask

    // follows the model pc until it leaves the emitted code
    task automatic run_program();
        logic [3:0]  wm;
        logic [31:0] wa;
        logic [31:0] wd;
        logic [31:0] lanes;
        logic [31:0] inst;
        while (mpc != emit_pc) begin
            inst = prog[(mpc - RESET_PC) >> 2];
            i_imem_rdata <= inst;
            @(negedge i_clk);
            check("o_imem_addr", mpc, o_imem_addr);
            // only loads read data memory
            check("o_dmem_ren", {31'b0, inst[6:2] == OPC_LOAD}, {31'b0, o_dmem_ren});
            iss_step(inst, wm, wa, wd);
            check("o_dmem_wmask", {28'b0, wm}, {28'b0, o_dmem_wmask});
            if (wm != 4'b0) begin
                lanes = {{8{wm[3]}}, {8{wm[2]}}, {8{wm[1]}}, {8{wm[0]}}};
                check("o_dmem_addr", wa, o_dmem_addr);
                check("o_dmem_wdata", wd & lanes, o_dmem_wdata & lanes);
            end
            @(posedge i_clk);
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            n_pass++;
            $display("%-12s passed", name);
        end else begin
            n_fail++;
            $display("%-12s failed with %0d errors", name, errors - errors_before);
        end
    endtask

    function automatic logic [31:0] rand_alu_inst();
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [2:0] f3;
        logic       alt;
        logic [11:0] imm;
        rd  = 5'($urandom);
        rs1 = 5'($urandom);
        rs2 = 5'($urandom);
        f3  = 3'($urandom);
        alt = (f3 == 3'd0 || f3 == 3'd5) && ($urandom % 2 == 1);
        imm = 12'($urandom);
        case ($urandom % 8)
            0, 1, 2: return enc_r({1'b0, alt, 5'b0}, rs2, rs1, f3, rd, OPC_OP);
            3, 4, 5: begin
                if (f3 == 3'd1 || f3 == 3'd5) begin
                    imm = {1'b0, alt && f3 == 3'd5, 5'b0, imm[4:0]};
                end
                return enc_i(imm, rs1, f3, rd, OPC_OP_IMM);
            end
            6:       return enc_u(20'($urandom), rd, OPC_LUI);
            default: return enc_u(20'($urandom), rd, OPC_AUIPC);
        endcase
    endfunction

    initial begin
        logic [2:0]  f3;
        logic [11:0] addr;
        logic [11:0] va;
        int          e0;
        void'($urandom(25803));
        i_clk        = 1'b0;
        i_rst_n      = 1'b0;
        i_imem_rdata = NOP;
        errors = 0;
        n_pass = 0;
        n_fail = 0;
        cycles = 0;
        for (int i = 0; i < 256; i++) begin
            dmem[i] = fill_word(i);
            mmem[i] = fill_word(i);
        end
        for (int i = 0; i < 32; i++) begin
            mreg[i] = '0;
        end
        for (int i = 0; i < 1024; i++) begin
            prog[i] = NOP;
        end
        mpc     = RESET_PC;
        emit_pc = RESET_PC;
        repeat (3) @(posedge i_clk);
        i_rst_n <= 1'b1;

        e0 = errors;
        emit(NOP);
        run_program();
        finish_test("reset", e0);

        e0 = errors;
        for (int i = 0; i < N_ALU; i++) begin
            emit(rand_alu_inst());
        end
        for (int r = 1; r < 32; r++) begin
            emit(enc_s(12'(4 * r), 5'(r), 5'd0, 3'd2));
        end
        run_program();
        finish_test("alu", e0);

        e0 = errors;
        for (int i = 0; i < N_LOAD; i++) begin
            case ($urandom % 5)
                0:       f3 = 3'd0;
                1:       f3 = 3'd1;
                2:       f3 = 3'd2;
                3:       f3 = 3'd4;
                default: f3 = 3'd5;
            endcase
            addr = 12'($urandom % 1024) & ~12'((1 << f3[1:0]) - 1);
            emit(enc_i(addr, 5'd0, f3, 5'd9, OPC_LOAD));
            emit(enc_s(12'd1020, 5'd9, 5'd0, 3'd2));
        end
        run_program();
        finish_test("loads", e0);

        e0 = errors;
        for (int r = 0; r < 4; r++) begin
            emit(enc_u(20'($urandom), 5'd10, OPC_LUI));
            emit(enc_i(12'($urandom), 5'd10, 3'd0, 5'd10, OPC_OP_IMM));
            for (int l = 0; l < 4; l++) begin
                emit(enc_s(12'(64 * r + l), 5'd10, 5'd0, 3'd0));
            end
            emit(enc_s(12'(64 * r + 16), 5'd10, 5'd0, 3'd1));
            emit(enc_s(12'(64 * r + 18), 5'd10, 5'd0, 3'd1));
            emit(enc_s(12'(64 * r + 32), 5'd10, 5'd0, 3'd2));
        end
        run_program();
        finish_test("stores", e0);

        e0 = errors;
        for (int i = 0; i < N_FLOW; i++) begin
            case ($urandom % 8)
                6: begin
                    emit(enc_j(21'd8, 5'd1));
                    emit(enc_i(12'd1, 5'd7, 3'd0, 5'd7, OPC_OP_IMM));
                    emit(enc_s(12'd1016, 5'd1, 5'd0, 3'd2));
                end
                7: begin
                    emit(enc_u(20'd0, 5'd2, OPC_AUIPC));
                    emit(enc_i(12'd12, 5'd2, 3'd0, 5'd3, OPC_JALR));
                    emit(enc_i(12'd1, 5'd7, 3'd0, 5'd7, OPC_OP_IMM));
                    emit(enc_s(12'd1012, 5'd3, 5'd0, 3'd2));
                end
                default: begin
                    va = 12'($urandom);
                    emit(enc_i(va, 5'd0, 3'd0, 5'd5, OPC_OP_IMM));
                    va = ($urandom % 3 == 0) ? va : 12'($urandom);
                    emit(enc_i(va, 5'd0, 3'd0, 5'd6, OPC_OP_IMM));
                    f3 = 3'($urandom % 6);
                    f3 = (f3 < 3'd2) ? f3 : f3 + 3'd2;
                    emit(enc_b(($urandom % 2 == 1) ? 13'd8 : 13'd12, 5'd6, 5'd5, f3));
                    emit(enc_i(12'd1, 5'd7, 3'd0, 5'd7, OPC_OP_IMM));
                    emit(enc_i(12'd2, 5'd7, 3'd0, 5'd7, OPC_OP_IMM));
                end
            endcase
        end
        emit(enc_s(12'd1008, 5'd7, 5'd0, 3'd2));
        run_program();
        finish_test("control", e0);

        $display("tests passed %0d failed %0d, %0d errors", n_pass, n_fail, errors);
        if (n_fail == 0 && errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+tb
common/rv_pkg.sv
rtl/rv_fetch.sv
decode/rv_decoder.sv
exec/rv_regfile.sv
exec/rv_branch_unit.sv
exec/rv_alu.sv
lsu/rv_store_align.sv
lsu/rv_load_writeback.sv
rtl/rv_core.sv
tb/tb_rv_core.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing -Wno-fatal -f all.f --top-module tb_rv_core -o tb_sim
	@out="$$(./obj_dir/tb_sim)"; echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir
